// File: common/block_pkg.sv
/*
 * block geometry and scan indices
 */

package block_pkg;

    // ****************************************
    // geometry
    // ****************************************

    localparam int blk_dim  = 8;
    localparam int blk_size = blk_dim * blk_dim;

    // flat coefficient index, row major
    typedef logic [5:0] coef_idx_t;

    // ****************************************
    // scan range
    // ****************************************

    // index 0 is DC, the rest are AC
    localparam coef_idx_t first_ac_idx = coef_idx_t'(1);
    localparam coef_idx_t last_ac_idx  = coef_idx_t'(blk_size - 1);

endpackage

// File: common/coef_pkg.sv
/*
 * coefficient and symbol formats
 * zero-run field width, run limit and run count type
 */

package coef_pkg;

    // ****************************************
    // symbol run field
    // ****************************************

    // upper field of an AC symbol
    localparam int run_width = 4;

    typedef logic [run_width-1:0] run_t;

    // sixteen zeros in a row become (max_run, 0)
    localparam run_t max_run = run_t'(15);

    // ****************************************
    // symbol layout
    // ****************************************

    // an AC symbol is {run, value}
    // value takes the low coef_width bits
    // coef_width itself is a module parameter

endpackage

// File: rle/coef_buffer.sv
/*
 * block capture register with DC output,
 * significance map and indexed AC read
 */
`timescale 1ns/100ps

module coef_buffer
    import block_pkg::*;
#(
    parameter int coef_width = 12
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic [coef_width-1:0]   block_in [blk_size],
    input  logic                    busy,
    input  coef_idx_t               scan_idx,
    output logic [blk_size-1:0]     sig_map,
    output logic [coef_width-1:0]   coef_out,
    output logic                    dc_valid,
    output logic [coef_width-1:0]   dc_data,
    output logic                    captured
);

    logic [coef_width-1:0]  block_q [blk_size];
    logic                   accept;
    logic                   cap_q;

    // a new block only when the scanner is free
    assign accept = start & ~busy;

    // ****************************************
    // capture
    // ****************************************

    always_ff @(posedge clk) begin
        if (accept) begin
            block_q <= block_in;
            dc_data <= block_in[0];
        end
    end

    // one-cycle pulse after an accepted start
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cap_q <= 1'b0;
        end else begin
            cap_q <= accept;
        end
    end

    // DC goes out in the same cycle the locator is kicked
    assign dc_valid = cap_q;
    assign captured = cap_q;

    // ****************************************
    // significance map and read port
    // ****************************************

    always_comb begin
        for (int i = 0; i < blk_size; i++) begin
            sig_map[i] = (block_q[i] != '0);
        end
    end

    // flat index, no reordering
    assign coef_out = block_q[scan_idx];

    // environment waits for busy low before the next block
    a_no_start_when_busy: assert property (
        @(posedge clk) disable iff (rst)
        !(start && busy)
    );

endmodule

// File: rle/eob_locator.sv
/*
 * end-of-block search over the significance map
 */
`timescale 1ns/100ps

module eob_locator
    import block_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                captured,
    input  logic [blk_size-1:0] sig_map,
    output coef_idx_t           last_nz,
    output logic                eob_ready
);

    coef_idx_t  nz_idx;
    logic       found;

    // ****************************************
    // priority search, highest AC index wins
    // ****************************************

    always_comb begin
        found  = 1'b0;
        nz_idx = '0;
        for (int i = last_ac_idx; i >= first_ac_idx; i--) begin
            if (sig_map[i] && !found) begin
                nz_idx = coef_idx_t'(i);
                found  = 1'b1;
            end
        end
    end

    // 0 left in last_nz means DC only
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_nz   <= '0;
            eob_ready <= 1'b0;
        end else begin
            eob_ready <= captured;
            if (captured) begin
                last_nz <= nz_idx;
            end
        end
    end

    // result must agree with the block held in the buffer
    a_last_nz_match: assert property (
        @(posedge clk) disable iff (rst)
        eob_ready |-> ((last_nz != '0) == (|sig_map[blk_size-1:first_ac_idx]))
                      && (last_nz == '0 || sig_map[last_nz])
    );

endmodule

// File: rle/run_scanner.sv
/*
 * AC scan with zero-run counting
 * emits (run, value), (15, 0) and end-of-block symbols
 */
`timescale 1ns/100ps

module run_scanner
    import block_pkg::*;
    import coef_pkg::*;
#(
    parameter int coef_width = 12
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            eob_ready,
    input  logic                            stall,
    input  coef_idx_t                       last_nz,
    input  logic [coef_width-1:0]           coef_in,
    output coef_idx_t                       scan_idx,
    output logic                            ac_valid,
    output logic [coef_width+run_width-1:0] ac_data,
    output logic                            last,
    output logic                            busy
);

    coef_idx_t  idx_q;
    run_t       run_q;
    logic       scan_q;
    logic       active;
    logic       step;
    logic       past_end;
    logic       coef_nz;
    logic       run_full;
    logic       finish;
    logic       emit;

    // ****************************************
    // per-index decision
    // ****************************************

    // scan begins in the eob_ready cycle itself
    assign active   = scan_q | eob_ready;
    assign step     = active & ~stall;
    assign scan_idx = idx_q;

    assign past_end = (idx_q > last_nz);
    assign coef_nz  = (coef_in != '0);
    assign run_full = (run_q == max_run);

    // coefficient 63 nonzero carries last itself, no EOB after it
    assign finish = past_end | (coef_nz & (idx_q == last_ac_idx));
    assign emit   = finish | coef_nz | run_full;

    // ****************************************
    // index and run count
    // ****************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_q <= 1'b0;
            idx_q  <= first_ac_idx;
            run_q  <= '0;
        end else if (step) begin
            if (finish) begin
                scan_q <= 1'b0;
                idx_q  <= first_ac_idx;
                run_q  <= '0;
            end else begin
                scan_q <= 1'b1;
                idx_q  <= coef_idx_t'(idx_q + 1'b1);
                // a symbol goes out, so the run starts over
                if (coef_nz || run_full) begin
                    run_q <= '0;
                end else begin
                    run_q <= run_t'(run_q + 1'b1);
                end
            end
        end else if (eob_ready) begin
            // stalled on the kick cycle, start on the next free one
            scan_q <= 1'b1;
        end
    end

    // ****************************************
    // symbol output
    // ****************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ac_valid <= 1'b0;
            last     <= 1'b0;
        end else begin
            ac_valid <= step & emit;
            last     <= step & finish;
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            if (past_end) begin
                ac_data <= '0;
            end else if (coef_nz) begin
                ac_data <= {run_q, coef_in};
            end else begin
                ac_data <= {max_run, {coef_width{1'b0}}};
            end
        end
    end

    // high from the first symbol until last drops
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (eob_ready) begin
            busy <= 1'b1;
        end else if (last) begin
            busy <= 1'b0;
        end
    end

    // a run of sixteen zeros is cut only while a nonzero value still follows
    a_run_limit: assert property (
        @(posedge clk) disable iff (rst)
        (step && run_full && !coef_nz && !past_end) |-> (idx_q < last_nz)
    );

    a_valid_in_busy: assert property (
        @(posedge clk) disable iff (rst)
        ac_valid |-> busy
    );

endmodule

// File: rle/rle_top.sv
/*
 * run-length encoder top for one 8x8 coefficient block
 * instances: coef_buffer, eob_locator, run_scanner
 */
`timescale 1ns/100ps

module rle_top
    import block_pkg::*;
    import coef_pkg::*;
#(
    parameter int coef_width = 12
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start,
    input  logic                                stall,
    input  logic [coef_width-1:0]               block_in [blk_size],
    output logic                                dc_valid,
    output logic [coef_width-1:0]               dc_data,
    output logic                                ac_valid,
    output logic [coef_width+run_width-1:0]     ac_data,
    output logic                                last,
    output logic                                busy
);

    // buffer to locator
    logic [blk_size-1:0]    sig_map;
    logic                   captured;

    // locator to scanner
    coef_idx_t              last_nz;
    logic                   eob_ready;

    // scanner read port into the buffer
    coef_idx_t              scan_idx;
    logic [coef_width-1:0]  coef_val;

    coef_buffer #(
        .coef_width (coef_width)
    ) u_coef_buffer (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .block_in   (block_in),
        .busy       (busy),
        .scan_idx   (scan_idx),
        .sig_map    (sig_map),
        .coef_out   (coef_val),
        .dc_valid   (dc_valid),
        .dc_data    (dc_data),
        .captured   (captured)
    );

    eob_locator u_eob_locator (
        .clk        (clk),
        .rst        (rst),
        .captured   (captured),
        .sig_map    (sig_map),
        .last_nz    (last_nz),
        .eob_ready  (eob_ready)
    );

    run_scanner #(
        .coef_width (coef_width)
    ) u_run_scanner (
        .clk        (clk),
        .rst        (rst),
        .eob_ready  (eob_ready),
        .stall      (stall),
        .last_nz    (last_nz),
        .coef_in    (coef_val),
        .scan_idx   (scan_idx),
        .ac_valid   (ac_valid),
        .ac_data    (ac_data),
        .last       (last),
        .busy       (busy)
    );

endmodule

// File: verif/rle_ref.svh
/*
 * reference model of the run-length encoder
 * xorshift generator for random stimulus
 */
`ifndef rle_ref_svh
`define rle_ref_svh

// ****************************************
// random numbers
// ****************************************

// xorshift32, one step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// ****************************************
// expected symbol list
// ****************************************

// one entry per AC symbol, {last, run, value}
// returns the number of entries
function automatic int ref_encode(
    input  logic [coef_width-1:0]           b [blk_size],
    output logic [coef_width+run_width:0]   s [blk_size]
);
    int n;
    int run;
    int last_nz;
    n       = 0;
    run     = 0;
    last_nz = 0;
    for (int i = 0; i < blk_size; i++) begin
        s[i] = '0;
    end
    // highest nonzero AC index, 0 if none
    for (int i = 1; i < blk_size; i++) begin
        if (b[i] != '0) begin
            last_nz = i;
        end
    end
    // zero-run limit only applies before the last nonzero value
    for (int i = 1; i <= last_nz; i++) begin
        if (b[i] != '0) begin
            s[n] = {(i == blk_size - 1), run_width'(run), b[i]};
            n++;
            run = 0;
        end else if (run == max_run) begin
            s[n] = {1'b0, max_run, {coef_width{1'b0}}};
            n++;
            run = 0;
        end else begin
            run++;
        end
    end
    // end of block unless coefficient 63 closed it already
    if (last_nz != blk_size - 1) begin
        s[n] = {1'b1, {(coef_width + run_width){1'b0}}};
        n++;
    end
    return n;
endfunction

`endif

// File: verif/rle_tb.sv
/*
 * testbench for rle_top: directed and random blocks,
 * stall injection, reference compare and watchdog
 */
`timescale 1ns/100ps

module rle_tb
    import block_pkg::*;
    import coef_pkg::*;
();

    localparam int coef_width = 12;
    localparam int sym_width  = coef_width + run_width;
    localparam int clk_period = 20;
    localparam int num_blocks = 66;

    logic                   clk;
    logic                   rst;
    logic                   start;
    logic                   stall;
    logic [coef_width-1:0]  block_in [blk_size];
    logic                   dc_valid;
    logic [coef_width-1:0]  dc_data;
    logic                   ac_valid;
    logic [sym_width-1:0]   ac_data;
    logic                   last;
    logic                   busy;

    logic [coef_width-1:0]  blk [blk_size];
    logic [sym_width:0]     syms [blk_size];
    logic [sym_width:0]     exp_q [$];
    logic [coef_width-1:0]  dc_q [$];
    logic [31:0]            rng;
    logic                   stall_seen;
    logic                   last_seen;
    int                     blocks_done;
    int                     checks;
    int                     errors;
    int                     tests;
    int                     test_err0;

    `include "rle_ref.svh"

    rle_top #(.coef_width(coef_width)) u_rle_top (.*);

    always #(clk_period / 2) clk = ~clk;

    // stall as the DUT saw it on this edge
    always @(posedge clk) begin
        stall_seen <= stall;
    end

    // ****************************************
    // compare
    // ****************************************

    always @(negedge clk) begin : compare
        logic [sym_width:0] exp;
        if (!rst) begin
            if (last_seen) begin
                checks++;
                assert (!busy) else begin
                    $display("busy still high one cycle after last");
                    errors++;
                end
            end
            last_seen = ac_valid && last;
            if (dc_valid) begin
                checks++;
                assert (dc_q.size() != 0) else begin
                    $display("dc_valid with no block started");
                    errors++;
                end
                if (dc_q.size() != 0) begin
                    assert (dc_data == dc_q[0]) else begin
                        $display("ERR dc_data got %h expected %h", dc_data, dc_q[0]);
                        errors++;
                    end
                    void'(dc_q.pop_front());
                end
            end
            if (ac_valid) begin
                checks++;
                assert (!stall_seen) else begin
                    $display("ac_valid high after a stalled cycle");
                    errors++;
                end
                assert (busy) else begin
                    $display("ac_valid high while busy is low");
                    errors++;
                end
                assert (exp_q.size() != 0) else begin
                    $display("extra symbol %h after the end of the block", ac_data);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    exp = exp_q.pop_front();
                    assert (ac_data == exp[sym_width-1:0]) else begin
                        $display("ERR ac_data got %h expected %h", ac_data, exp[sym_width-1:0]);
                        errors++;
                    end
                    assert (last == exp[sym_width]) else begin
                        if (last) begin
                            $display("last set before the final symbol of the block");
                        end else begin
                            $display("last missing on the final symbol of the block");
                        end
                        errors++;
                    end
                end
                if (last) begin
                    blocks_done++;
                end
            end
        end
    end

    // ****************************************
    // stimulus
    // ****************************************

    task automatic rand_block();
        for (int i = 0; i < blk_size; i++) begin
            rng = xorshift32(rng);
            // about one AC value in four is nonzero
            blk[i] = (i == 0 || rng[31:30] == 2'b00) ? rng[coef_width-1:0] : '0;
        end
    endtask

    task automatic run_block(input logic with_stall);
        int target;
        int n;
        target = blocks_done + 1;
        n      = ref_encode(blk, syms);
        dc_q.push_back(blk[0]);
        for (int i = 0; i < n; i++) begin
            exp_q.push_back(syms[i]);
        end
        block_in = blk;
        start    = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (blocks_done < target) begin
            if (with_stall) begin
                rng   = xorshift32(rng);
                stall = rng[0];
            end
            @(negedge clk);
        end
        stall = 1'b0;
        while (busy) begin
            @(negedge clk);
        end
        checks++;
        assert (exp_q.size() == 0 && dc_q.size() == 0) else begin
            $display("block ended with %0d symbols and %0d DC values not seen",
                     exp_q.size(), dc_q.size());
            errors++;
        end
        exp_q.delete();
        dc_q.delete();
    endtask

    task automatic end_test(input string name);
        if (errors == test_err0) begin
            $display("test %0d %s: ok", tests + 1, name);
        end else begin
            $display("test %0d %s: %0d errors", tests + 1, name, errors - test_err0);
        end
        test_err0 = errors;
        tests++;
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        start       = 1'b0;
        stall       = 1'b0;
        rng         = 32'h0a90_64e8;
        last_seen   = 1'b0;
        blocks_done = 0;
        checks      = 0;
        errors      = 0;
        tests       = 0;
        test_err0   = 0;
        blk         = '{default: '0};
        block_in    = blk;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        blk[0] = 12'h5a3;
        run_block(1'b0);
        end_test("dc only");

        blk     = '{default: '0};
        blk[63] = 12'hffb;
        run_block(1'b0);
        end_test("last coefficient nonzero");

        blk     = '{default: '0};
        blk[0]  = 12'h801;
        blk[1]  = 12'h012;
        blk[40] = 12'hf80;
        run_block(1'b0);
        end_test("zero-run limit");

        repeat (50) begin
            rand_block();
            run_block(1'b0);
        end
        end_test("random blocks");

        repeat (10) begin
            rand_block();
            run_block(1'b1);
        end
        end_test("stall");

        // back to back blocks with every coefficient nonzero, then empty, then random
        for (int i = 0; i < blk_size; i++) begin
            blk[i] = coef_width'(i + 1);
        end
        run_block(1'b0);
        blk = '{default: '0};
        run_block(1'b0);
        rand_block();
        run_block(1'b0);
        end_test("busy and start");

        $display("%0d tests, %0d blocks, %0d checks, %0d errors",
                 tests, blocks_done, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // 200 cycles per block plus reset
    initial begin : watchdog
        #(200 * num_blocks * clk_period + 20 * clk_period);
        $display("watchdog expired after %0d of %0d blocks", blocks_done, num_blocks);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+verif
common/block_pkg.sv
common/coef_pkg.sv
rle/coef_buffer.sv
rle/eob_locator.sv
rle/run_scanner.sv
rle/rle_top.sv
verif/rle_tb.sv
